// ==== execute_core.f ====
logic/execute_pkg.sv
logic/alu.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/writeback_latch.sv
logic/execute_top.sv
tests/execute_tb.sv

// ==== Makefile ====
# Verilator simulation of the execute core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module execute_tb -f execute_core.f
	./obj_dir/Vexecute_tb | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/execute_tb.sv ====
// testbench for the execute part that checks decoded instructions against a latch model
`timescale 1ns/10ps

module execute_tb;

    import execute_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_ALU        = 20;
    // instructions issued by tests 2 to 6
    localparam int N_FIXED      = 20;
    localparam int TOTAL_INSTR  = N_ALU + N_FIXED;

    logic       CLK;
    logic       nRST;
    decode_t    decode_p;
    logic       ihit;
    logic       dhit;
    logic       freeze;
    logic       flush;
    word_t      dload;
    logic       dmem_ren;
    logic       dmem_wen;
    word_t      dmem_addr;
    word_t      dmem_store;
    logic       reg_wen;
    regbits_t   reg_wsel;
    word_t      reg_wdat;
    logic       halt;
    word_t      npc_wb;

    // reference copies of the two latches
    execute_t   m_ex;
    writeback_t m_wb;

    integer     seed;
    int         errors;
    int         passes;
    int         fails;
    int         err_mark;
    int         test_num;
    string      test_name;

    execute_top UUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .decode_p   (decode_p),
        .ihit       (ihit),
        .dhit       (dhit),
        .freeze     (freeze),
        .flush      (flush),
        .dload      (dload),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .reg_wen    (reg_wen),
        .reg_wsel   (reg_wsel),
        .reg_wdat   (reg_wdat),
        .halt       (halt),
        .npc_wb     (npc_wb)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic word_t alu_model(input aluop_t op, input word_t a, input word_t b);
        case (op)
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    // youngest matching producer supplies the value and r0 never does
    function automatic word_t resolve_operand(input regbits_t src, input word_t dec_val);
        if (src != 5'd0 && m_ex.reg_wen && m_ex.rw == src) return m_ex.port_o;
        if (src != 5'd0 && m_wb.reg_wen && m_wb.rw == src) return m_wb.wdat;
        return dec_val;
    endfunction

    function automatic execute_t predict_execute(input decode_t d);
        execute_t e;
        word_t    a;
        word_t    b;
        a            = resolve_operand(d.rs, d.port_a);
        b            = resolve_operand(d.rt, d.port_b);
        e.rw         = d.rw;
        e.reg_wen    = d.reg_wen;
        e.mem_to_reg = d.mem_to_reg;
        e.dren       = d.dren;
        e.dwen       = d.dwen;
        e.halt       = d.halt;
        e.npc        = d.npc;
        e.port_o     = alu_model(d.alu_op, a, d.alu_src ? d.imm_ext : b);
        e.store_data = b;
        return e;
    endfunction

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            m_ex <= '0;
            m_wb <= '0;
        end else begin
            if (flush || dhit) begin
                m_ex <= '0;
            end else if (!freeze && ihit) begin
                m_ex <= predict_execute(decode_p);
            end
            if (!freeze && (ihit || dhit)) begin
                m_wb <= '{rw: m_ex.rw, reg_wen: m_ex.reg_wen, halt: m_ex.halt, npc: m_ex.npc,
                          wdat: m_ex.mem_to_reg ? dload : m_ex.port_o};
            end
        end
    end

    wdat_check: assert property (@(posedge CLK) disable iff (!nRST)
        reg_wen |-> reg_wdat == m_wb.wdat) else begin
        errors++;
        $display("** Error %s: reg_wdat expected %h actual %h", test_name,
                 $sampled(m_wb.wdat), $sampled(reg_wdat));
    end

    wsel_check: assert property (@(posedge CLK) disable iff (!nRST)
        reg_wen |-> reg_wsel == m_wb.rw) else begin
        errors++;
        $display("** Error %s: reg_wsel expected %0d actual %0d", test_name,
                 $sampled(m_wb.rw), $sampled(reg_wsel));
    end

    npc_check: assert property (@(posedge CLK) disable iff (!nRST)
        (reg_wen || halt) |-> npc_wb == m_wb.npc) else begin
        errors++;
        $display("** Error %s: npc_wb expected %h actual %h", test_name,
                 $sampled(m_wb.npc), $sampled(npc_wb));
    end

    addr_check: assert property (@(posedge CLK) disable iff (!nRST)
        (dmem_ren || dmem_wen) |-> dmem_addr == m_ex.port_o) else begin
        errors++;
        $display("** Error %s: dmem_addr expected %h actual %h", test_name,
                 $sampled(m_ex.port_o), $sampled(dmem_addr));
    end

    store_check: assert property (@(posedge CLK) disable iff (!nRST)
        (dmem_ren || dmem_wen) |-> dmem_store == m_ex.store_data) else begin
        errors++;
        $display("** Error %s: dmem_store expected %h actual %h", test_name,
                 $sampled(m_ex.store_data), $sampled(dmem_store));
    end

    // enables and halt follow the model on every cycle even after a flush
    control_check: assert property (@(posedge CLK) disable iff (!nRST)
        {dmem_ren, dmem_wen, reg_wen, halt} == {m_ex.dren, m_ex.dwen, m_wb.reg_wen, m_wb.halt})
        else begin
        errors++;
        $display("** Error %s: ren/wen/reg_wen/halt expected %b actual %b", test_name,
                 $sampled({m_ex.dren, m_ex.dwen, m_wb.reg_wen, m_wb.halt}),
                 $sampled({dmem_ren, dmem_wen, reg_wen, halt}));
    end

    hold_check: assert property (@(posedge CLK) disable iff (!nRST)
        ((freeze || !ihit) && !flush && !dhit) |=>
        $stable({reg_wen, reg_wsel, reg_wdat, dmem_ren, dmem_wen, dmem_addr, dmem_store}))
        else begin
        errors++;
        $display("%s: outputs changed while the pipeline was held", test_name);
    end

    function automatic decode_t make_instr(input aluop_t op, input regbits_t rs,
                                           input regbits_t rt, input regbits_t rw);
        decode_t d;
        d         = '0;
        d.alu_op  = op;
        d.rs      = rs;
        d.rt      = rt;
        d.rw      = rw;
        d.port_a  = $random(seed);
        d.port_b  = $random(seed);
        d.imm_ext = $random(seed);
        d.npc     = $random(seed);
        d.reg_wen = 1'b1;
        return d;
    endfunction

    task automatic issue(input decode_t d);
        @(posedge CLK);
        decode_p <= d;
        ihit     <= 1'b1;
        dhit     <= 1'b0;
        freeze   <= 1'b0;
        flush    <= 1'b0;
    endtask

    task automatic start_test(input int num, input string name);
        test_num  = num;
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic finish_test();
        repeat (3) issue('0);
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        if (errors == err_mark) begin
            passes++;
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            fails++;
            $display("test %0d %s: FAILED, %0d errors", test_num, test_name, errors - err_mark);
        end
    endtask

    initial begin
        #((TOTAL_INSTR * 4 + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        decode_t d;
        logic [3:0] code;
        seed     = 11267;
        errors   = 0;
        passes   = 0;
        fails    = 0;
        CLK      = 1'b0;
        nRST     = 1'b0;
        decode_p = '0;
        ihit     = 1'b0;
        dhit     = 1'b0;
        freeze   = 1'b0;
        flush    = 1'b0;
        dload    = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        start_test(1, "alu operations");
        for (int i = 0; i < N_ALU; i++) begin
            code = 4'(i % 10);
            issue(make_instr(aluop_t'(code), 5'd0, 5'd0, 5'(i + 1)));
        end
        finish_test();

        start_test(2, "immediate priority");
        issue(make_instr(ALU_ADD, 5'd0, 5'd0, 5'd5));
        d         = make_instr(ALU_ADD, 5'd0, 5'd5, 5'd0);
        d.alu_src = 1'b1;
        d.dwen    = 1'b1;
        d.reg_wen = 1'b0;
        issue(d);
        finish_test();

        start_test(3, "forwarding");
        issue(make_instr(ALU_ADD, 5'd0, 5'd0, 5'd3));
        issue(make_instr(ALU_XOR, 5'd3, 5'd3, 5'd4));
        issue(make_instr(ALU_SUB, 5'd3, 5'd4, 5'd5));
        // r6 sits in both latches and the execute copy wins
        issue(make_instr(ALU_OR, 5'd0, 5'd0, 5'd6));
        issue(make_instr(ALU_AND, 5'd0, 5'd0, 5'd6));
        issue(make_instr(ALU_ADD, 5'd6, 5'd6, 5'd12));
        // r0 is written here but must not reach the next instruction
        issue(make_instr(ALU_ADD, 5'd0, 5'd0, 5'd0));
        issue(make_instr(ALU_SUB, 5'd0, 5'd0, 5'd13));
        finish_test();

        start_test(4, "loads");
        d            = make_instr(ALU_ADD, 5'd0, 5'd0, 5'd7);
        d.alu_src    = 1'b1;
        d.dren       = 1'b1;
        d.mem_to_reg = 1'b1;
        issue(d);
        @(posedge CLK);
        decode_p <= '0;
        ihit     <= 1'b0;
        dhit     <= 1'b1;
        dload    <= $random(seed);
        // consumer of the loaded word forwarded from write-back
        issue(make_instr(ALU_ADD, 5'd7, 5'd7, 5'd8));
        finish_test();

        start_test(5, "pipeline control");
        issue(make_instr(ALU_ADD, 5'd0, 5'd0, 5'd9));
        issue(make_instr(ALU_SUB, 5'd9, 5'd0, 5'd10));
        @(posedge CLK);
        freeze <= 1'b1;
        repeat (3) @(posedge CLK);
        d      = make_instr(ALU_OR, 5'd10, 5'd9, 5'd11);
        d.dwen = 1'b1;
        issue(d);
        @(posedge CLK);
        flush <= 1'b1;
        issue('0);
        @(posedge CLK);
        ihit     <= 1'b0;
        decode_p <= make_instr(ALU_NOR, 5'd11, 5'd10, 5'd14);
        repeat (3) @(posedge CLK);
        finish_test();

        start_test(6, "reset and halt");
        // both latches hold enables and halt when reset arrives
        d      = make_instr(ALU_ADD, 5'd0, 5'd0, 5'd15);
        d.dren = 1'b1;
        d.dwen = 1'b1;
        d.halt = 1'b1;
        issue(d);
        issue(d);
        @(posedge CLK);
        nRST     <= 1'b0;
        ihit     <= 1'b0;
        decode_p <= '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        reset_check: assert ({dmem_ren, dmem_wen, reg_wen, halt} == 4'b0000) else begin
            errors++;
            $display("** Error %s: ren/wen/reg_wen/halt expected 0000 actual %b", test_name,
                     {dmem_ren, dmem_wen, reg_wen, halt});
        end
        d         = make_instr(ALU_ADD, 5'd0, 5'd0, 5'd0);
        d.reg_wen = 1'b0;
        d.halt    = 1'b1;
        issue(d);
        issue('0);
        @(posedge CLK);
        @(negedge CLK);
        halt_check: assert (halt == 1'b1) else begin
            errors++;
            $display("** Error %s: halt expected 1 actual %b", test_name, halt);
        end
        finish_test();

        $display("%0d tests passed, %0d tests failed, %0d errors", passes, fails, errors);
        if (fails == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== logic/execute_top.sv ====
// top of the execute part: forward unit, execute stage and write-back latch wired together
`timescale 1ns/10ps

module execute_top (
    input  logic                  CLK,
    input  logic                  nRST,
    input  execute_pkg::decode_t  decode_p,
    input  logic                  ihit,
    input  logic                  dhit,
    input  logic                  freeze,
    input  logic                  flush,
    input  execute_pkg::word_t    dload,
    output logic                  dmem_ren,
    output logic                  dmem_wen,
    output execute_pkg::word_t    dmem_addr,
    output execute_pkg::word_t    dmem_store,
    output logic                  reg_wen,
    output execute_pkg::regbits_t reg_wsel,
    output execute_pkg::word_t    reg_wdat,
    output logic                  halt,
    output execute_pkg::word_t    npc_wb
);

    import execute_pkg::*;

    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;
    execute_t   execute_p;
    writeback_t wb_p;

    forward_unit u_fwd (
        .rs         (decode_p.rs),
        .rt         (decode_p.rt),
        .ex_rw      (execute_p.rw),
        .ex_reg_wen (execute_p.reg_wen),
        .wb_rw      (wb_p.rw),
        .wb_reg_wen (wb_p.reg_wen),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    execute_stage u_ex (
        .CLK       (CLK),
        .nRST      (nRST),
        .decode_p  (decode_p),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .wb_data   (wb_p.wdat),
        .ihit      (ihit),
        .dhit      (dhit),
        .freeze    (freeze),
        .flush     (flush),
        .execute_p (execute_p)
    );

    writeback_latch u_wb (
        .CLK       (CLK),
        .nRST      (nRST),
        .execute_p (execute_p),
        .dload     (dload),
        .ihit      (ihit),
        .dhit      (dhit),
        .freeze    (freeze),
        .wb_p      (wb_p)
    );

    // data memory side
    assign dmem_ren   = execute_p.dren;
    assign dmem_wen   = execute_p.dwen;
    assign dmem_addr  = execute_p.port_o;
    assign dmem_store = execute_p.store_data;

    // register file side
    assign reg_wen  = wb_p.reg_wen;
    assign reg_wsel = wb_p.rw;
    assign reg_wdat = wb_p.wdat;
    assign halt     = wb_p.halt;
    assign npc_wb   = wb_p.npc;

endmodule

// ==== logic/writeback_latch.sv ====
// memory/write-back latch: picks load data or ALU result and drives the register write port
`timescale 1ns/10ps

module writeback_latch (
    input  logic                    CLK,
    input  logic                    nRST,
    input  execute_pkg::execute_t   execute_p,
    input  execute_pkg::word_t      dload,
    input  logic                    ihit,
    input  logic                    dhit,
    input  logic                    freeze,
    output execute_pkg::writeback_t wb_p
);

    import execute_pkg::*;

    writeback_t wb_n;

    always_comb begin
        wb_n.rw      = execute_p.rw;
        wb_n.reg_wen = execute_p.reg_wen;
        wb_n.halt    = execute_p.halt;
        wb_n.npc     = execute_p.npc;
        // loads write the memory word, everything else the ALU result
        wb_n.wdat    = execute_p.mem_to_reg ? dload : execute_p.port_o;
    end

    // dhit also advances so a finished load is not lost
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_p <= '0;
        end else if (freeze) begin
            wb_p <= wb_p;
        end else if (ihit || dhit) begin
            wb_p <= wb_n;
        end
    end

    // held write-back data also feeds forwarding, so it has to stay put
    a_hold_on_freeze: assert property (
        @(posedge CLK) disable iff (!nRST)
        freeze |=> $stable(wb_p)
    ) else $error("write-back latch changed under freeze");

endmodule

// ==== logic/execute_stage.sv ====
// execute stage: operand forwarding muxes, the ALU and the execute/memory pipeline latch
`timescale 1ns/10ps

module execute_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  execute_pkg::decode_t  decode_p,
    input  execute_pkg::fwd_sel_t fwd_a,
    input  execute_pkg::fwd_sel_t fwd_b,
    input  execute_pkg::word_t    wb_data,
    input  logic                  ihit,
    input  logic                  dhit,
    input  logic                  freeze,
    input  logic                  flush,
    output execute_pkg::execute_t execute_p
);

    import execute_pkg::*;

    word_t    fwd_a_data;
    word_t    fwd_b_data;
    word_t    alu_b;
    word_t    alu_out;
    execute_t execute_n;

    function automatic word_t fwd_mux(
        input fwd_sel_t sel,
        input word_t    dec_val,
        input word_t    ex_val,
        input word_t    wb_val
    );
        word_t val;
        case (sel)
            FWD_EX:  val = ex_val;
            FWD_WB:  val = wb_val;
            default: val = dec_val;
        endcase
        return val;
    endfunction

    always_comb begin
        fwd_a_data = fwd_mux(fwd_a, decode_p.port_a, execute_p.port_o, wb_data);
        fwd_b_data = fwd_mux(fwd_b, decode_p.port_b, execute_p.port_o, wb_data);
        // immediate takes priority over any forwarding on operand b
        alu_b = decode_p.alu_src ? decode_p.imm_ext : fwd_b_data;
    end

    alu u_alu (
        .aluop (decode_p.alu_op),
        .porta (fwd_a_data),
        .portb (alu_b),
        .oport (alu_out)
    );

    // next latch contents
    always_comb begin
        execute_n.rw         = decode_p.rw;
        execute_n.reg_wen    = decode_p.reg_wen;
        execute_n.mem_to_reg = decode_p.mem_to_reg;
        execute_n.dren       = decode_p.dren;
        execute_n.dwen       = decode_p.dwen;
        execute_n.halt       = decode_p.halt;
        execute_n.npc        = decode_p.npc;
        execute_n.port_o     = alu_out;
        // stores always see the forwarded rt value
        execute_n.store_data = fwd_b_data;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            execute_p <= '0;
        end else if (flush || dhit) begin
            execute_p <= '0;
        end else if (freeze) begin
            execute_p <= execute_p;
        end else if (ihit) begin
            execute_p <= execute_n;
        end
    end

    // a cleared latch must not carry anything into memory or write-back
    a_clear_on_flush: assert property (
        @(posedge CLK) disable iff (!nRST)
        (flush || dhit) |=> (execute_p == '0)
    ) else $error("execute latch not cleared after flush or dhit");

    a_hold_on_freeze: assert property (
        @(posedge CLK) disable iff (!nRST)
        (freeze && !flush && !dhit) |=> $stable(execute_p)
    ) else $error("execute latch changed under freeze");

    a_known_aluop: assert property (
        @(posedge CLK) disable iff (!nRST)
        ihit |-> !$isunknown(decode_p.alu_op)
    ) else $error("unknown ALU operation while advancing");

endmodule

// ==== logic/forward_unit.sv ====
// picks the forwarding source of each ALU operand from the execute and write-back latches
`timescale 1ns/10ps

module forward_unit (
    input  execute_pkg::regbits_t rs,
    input  execute_pkg::regbits_t rt,
    input  execute_pkg::regbits_t ex_rw,
    input  logic                  ex_reg_wen,
    input  execute_pkg::regbits_t wb_rw,
    input  logic                  wb_reg_wen,
    output execute_pkg::fwd_sel_t fwd_a,
    output execute_pkg::fwd_sel_t fwd_b
);

    import execute_pkg::*;

    // youngest producer wins, register 0 never forwards
    function automatic fwd_sel_t pick_source(
        input regbits_t src,
        input regbits_t ex_dst,
        input logic     ex_wen,
        input regbits_t wb_dst,
        input logic     wb_wen
    );
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (src != '0) begin
            if (ex_wen && ex_dst == src) begin
                sel = FWD_EX;
            end else if (wb_wen && wb_dst == src) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_source(rs, ex_rw, ex_reg_wen, wb_rw, wb_reg_wen);
        fwd_b = pick_source(rt, ex_rw, ex_reg_wen, wb_rw, wb_reg_wen);
    end

endmodule

// ==== logic/alu.sv ====
// combinational 32-bit ALU, one operation per cycle, instantiated by the execute stage
`timescale 1ns/10ps

module alu (
    input  execute_pkg::aluop_t aluop,
    input  execute_pkg::word_t  porta,
    input  execute_pkg::word_t  portb,
    output execute_pkg::word_t  oport
);

    import execute_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    // shift amount is the low bits of operand b
    assign shamt = portb[SHAMT_W-1:0];

    always_comb begin
        case (aluop)
            ALU_SLL: begin
                oport = porta << shamt;
            end
            ALU_SRL: begin
                oport = porta >> shamt;
            end
            ALU_ADD: begin
                oport = porta + portb;
            end
            ALU_SUB: begin
                oport = porta - portb;
            end
            ALU_AND: begin
                oport = porta & portb;
            end
            ALU_OR: begin
                oport = porta | portb;
            end
            ALU_XOR: begin
                oport = porta ^ portb;
            end
            ALU_NOR: begin
                oport = ~(porta | portb);
            end
            // set on less than, result is 1 or 0
            ALU_SLT: begin
                oport = word_t'($signed(porta) < $signed(portb));
            end
            ALU_SLTU: begin
                oport = word_t'(porta < portb);
            end
            default: begin
                oport = '0;
            end
        endcase
    end

endmodule

// ==== logic/execute_pkg.sv ====
// shared word, register, ALU and pipeline latch types; imported by every execute-side module
package execute_pkg;

    // fixed datapath widths of the instruction set
    parameter int WORD_W  = 32;
    parameter int REG_W   = 5;
    parameter int SHAMT_W = $clog2(WORD_W);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  regbits_t;

    typedef enum logic [3:0] {
        ALU_SLL  = 4'd0,
        ALU_SRL  = 4'd1,
        ALU_ADD  = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluop_t;

    // where one ALU operand comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    // decode latch contents, driven from outside
    typedef struct packed {
        aluop_t   alu_op;
        regbits_t rs;
        regbits_t rt;
        regbits_t rw;
        word_t    port_a;
        word_t    port_b;
        word_t    imm_ext;
        logic     alu_src;
        logic     dren;
        logic     dwen;
        logic     reg_wen;
        logic     mem_to_reg;
        logic     halt;
        word_t    npc;
    } decode_t;

    // execute/memory latch
    typedef struct packed {
        regbits_t rw;
        logic     reg_wen;
        logic     mem_to_reg;
        logic     dren;
        logic     dwen;
        logic     halt;
        word_t    npc;
        word_t    port_o;
        word_t    store_data;
    } execute_t;

    // memory/write-back latch
    typedef struct packed {
        regbits_t rw;
        logic     reg_wen;
        logic     halt;
        word_t    npc;
        word_t    wdat;
    } writeback_t;

endpackage
